//--- pipe_core.f
common/core_pkg.sv
src/decode/regfile.sv
src/decode/decoder.sv
src/decode/id_stage.sv
src/execute/ex_stage.sv
src/wb_stage.sv
src/pipe_core.sv
tests/pipe_core_tb.sv

//--- Makefile
# Verilator build and run for pipe_core

VERILATOR ?= verilator
TOP       ?= pipe_core_tb
FILELIST  ?= pipe_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/pipe_core_tb.sv
// pipe_core_tb: clock, lfsr, reference register model, stimulus, retire assertions, watchdog
module pipe_core_tb;

  localparam int clk_period    = 40;
  localparam int drive_dly     = 2;    // inputs change this long after the rising edge
  localparam int n_slots       = 100;  // upper bound on reset + issue + drain cycles
  localparam int margin_cycles = 50;

  logic                                clock = 1'b0;
  logic                                rst;
  logic                                inst_valid;
  logic [core_pkg::inst_w-1:0]         inst;
  logic                                wb_valid, wb_illegal, halted;
  logic [core_pkg::reg_idx_w-1:0]      wb_idx;
  logic [core_pkg::xlen-1:0]           wb_data;

  int          cycle_cnt = 0;             // rising edges seen so far
  logic [31:0] lfsr      = 32'h767b_a9c5;
  logic [63:0] ref_regs [32];             // reference architectural state
  bit          halt_sent = 1'b0;
  int          halt_tag  = 0;             // edge count at which halted must rise

  // expected retires with the oldest first
  int          exp_cyc  [$];
  logic [4:0]  exp_idx  [$];
  logic [63:0] exp_data [$];
  bit          exp_ill  [$];

  pipe_core u_pipe_core (
    .clock (clock), .rst (rst), .inst_valid (inst_valid), .inst (inst),
    .wb_valid (wb_valid), .wb_illegal (wb_illegal), .wb_idx (wb_idx),
    .wb_data (wb_data), .halted (halted)
  );

  always #(clk_period/2) clock = ~clock;
  always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////
  task automatic end_failed();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic stop_failed(input string what);
    $display("Error: %s", what);
    end_failed();
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
    $display("Error: %s = %h, expected %h", sig, got, exp);
    end_failed();
  endtask

  //////////////////////////////////////////////////
  // lfsr, encoding, reference model
  //////////////////////////////////////////////////
  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};        // one step per bit
    end
  endtask

  function automatic logic [31:0] enc_reg(input logic [5:0] op, input logic [4:0] ra,
                                          input logic [4:0] rb, input logic [6:0] fn,
                                          input logic [4:0] rc);
    return {op, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  function automatic logic [31:0] enc_lit(input logic [5:0] op, input logic [4:0] ra,
                                          input logic [7:0] lit, input logic [6:0] fn,
                                          input logic [4:0] rc);
    return {op, ra, lit, 1'b1, fn, rc};
  endfunction

  function automatic logic [63:0] read_ref(input logic [4:0] idx);
    return (idx == 5'd31) ? 64'd0 : ref_regs[idx];    // r31 always zero
  endfunction

  // expected retire from model state at issue before the model update
  task automatic predict(input logic [31:0] w);
    logic [5:0]  op;
    logic [6:0]  fn;
    logic [4:0]  rc;
    logic [63:0] a, b, res;
    bit          ill;
    op  = w[31:26];
    fn  = w[11:5];
    rc  = w[4:0];
    a   = read_ref(w[25:21]);
    b   = w[12] ? {56'd0, w[20:13]} : read_ref(w[20:16]);
    ill = 1'b0;
    res = 64'd0;
    case (op)
      core_pkg::op_intarith: begin
        case (fn)
          core_pkg::fn_add:   res = a + b;
          core_pkg::fn_sub:   res = a - b;
          core_pkg::fn_cmpeq: res = {63'd0, (a == b)};
          default:            ill = 1'b1;
        endcase
      end
      core_pkg::op_intlogic: begin
        case (fn)
          core_pkg::fn_and: res = a & b;
          core_pkg::fn_or:  res = a | b;
          core_pkg::fn_xor: res = a ^ b;
          default:          ill = 1'b1;
        endcase
      end
      core_pkg::op_intshift: begin
        case (fn)
          core_pkg::fn_sll: res = a << b[5:0];   // amount from low 6 bits
          core_pkg::fn_srl: res = a >> b[5:0];
          default:          ill = 1'b1;
        endcase
      end
      default: ill = 1'b1;
    endcase
    if (op == core_pkg::op_halt) begin
      halt_sent = 1'b1;                  // halt gives no retire pulse and only raises halted
      halt_tag  = cycle_cnt + 3;
    end else begin
      exp_cyc.push_back(cycle_cnt + 3);  // accept edge then two more stages
      exp_idx.push_back(rc);
      exp_data.push_back(ill ? 64'd0 : res);
      exp_ill.push_back(ill);
      if (!ill && rc != 5'd31) ref_regs[rc] = res;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  task automatic issue(input logic [31:0] w);
    inst_valid = 1'b1;
    inst       = w;
    predict(w);
    @(posedge clock);
    #drive_dly;
  endtask

  task automatic idle();
    inst_valid = 1'b0;
    inst       = '0;
    @(posedge clock);
    #drive_dly;
  endtask

  // one function in register form then literal form with random operands
  task automatic sweep_one(input logic [5:0] op, input logic [6:0] fn);
    logic [31:0] ra, rb, rc, lit;
    take_bits(5, ra);
    take_bits(5, rb);
    take_bits(5, rc);
    take_bits(8, lit);
    issue(enc_reg(op, ra[4:0], rb[4:0], fn, rc[4:0]));
    take_bits(5, rc);
    issue(enc_lit(op, ra[4:0], lit[7:0], fn, rc[4:0]));
  endtask

  //////////////////////////////////////////////////
  // retire checks sampled on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clock) begin
    if (!rst) begin
      if (wb_valid) begin
        assert (exp_cyc.size() != 0) else stop_failed("wb_valid pulse with nothing outstanding");
        assert (cycle_cnt == exp_cyc[0])
          else stop_failed($sformatf("retire at edge %0d, expected edge %0d",
                                     cycle_cnt, exp_cyc[0]));
        assert (wb_idx == exp_idx[0]) else report_mismatch("wb_idx", 64'(wb_idx), 64'(exp_idx[0]));
        assert (wb_data == exp_data[0]) else report_mismatch("wb_data", wb_data, exp_data[0]);
        assert (wb_illegal == exp_ill[0])
          else report_mismatch("wb_illegal", 64'(wb_illegal), 64'(exp_ill[0]));
        void'(exp_cyc.pop_front());
        void'(exp_idx.pop_front());
        void'(exp_data.pop_front());
        void'(exp_ill.pop_front());
      end else begin
        assert (!wb_illegal) else report_mismatch("wb_illegal", 64'(wb_illegal), 64'd0);
        assert (exp_cyc.size() == 0 || exp_cyc[0] > cycle_cnt)
          else stop_failed("expected retire did not appear");
      end
      if (halt_sent && cycle_cnt >= halt_tag) begin
        assert (halted) else report_mismatch("halted", 64'(halted), 64'd1);
      end else begin
        assert (!halted) else report_mismatch("halted", 64'(halted), 64'd0);
      end
    end
  end

  // watchdog
  initial begin
    #((n_slots + margin_cycles) * clk_period);
    stop_failed("watchdog timeout, run did not finish");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (5) @(posedge clock);
    #drive_dly;
    rst = 1'b0;
    // load every register by or-ing r31 with a random literal
    for (int i = 0; i < 31; i++) begin
      take_bits(8, r);
      issue(enc_lit(core_pkg::op_intlogic, core_pkg::zero_reg, r[7:0], core_pkg::fn_or, 5'(i)));
    end
    sweep_one(core_pkg::op_intarith, core_pkg::fn_add);
    sweep_one(core_pkg::op_intarith, core_pkg::fn_sub);
    sweep_one(core_pkg::op_intarith, core_pkg::fn_cmpeq);
    sweep_one(core_pkg::op_intlogic, core_pkg::fn_and);
    sweep_one(core_pkg::op_intlogic, core_pkg::fn_or);
    sweep_one(core_pkg::op_intlogic, core_pkg::fn_xor);
    sweep_one(core_pkg::op_intshift, core_pkg::fn_sll);
    sweep_one(core_pkg::op_intshift, core_pkg::fn_srl);
    issue(enc_reg(core_pkg::op_intarith, 5'd4, 5'd4, core_pkg::fn_cmpeq, 5'd9));  // equal case
    // distance 1 uses the bypass on both ports
    issue(enc_lit(core_pkg::op_intarith, 5'd1, 8'h11, core_pkg::fn_add, 5'd2));
    issue(enc_reg(core_pkg::op_intarith, 5'd2, 5'd2, core_pkg::fn_add, 5'd3));
    // distance 2 reads rb through write-through
    issue(enc_lit(core_pkg::op_intlogic, 5'd3, 8'hf0, core_pkg::fn_xor, 5'd4));
    issue(enc_lit(core_pkg::op_intarith, 5'd5, 8'h01, core_pkg::fn_add, 5'd6));
    issue(enc_reg(core_pkg::op_intlogic, 5'd7, 5'd4, core_pkg::fn_or, 5'd8));
    // distance 3 reads from the array across a bubble
    issue(enc_lit(core_pkg::op_intshift, 5'd8, 8'h03, core_pkg::fn_sll, 5'd16));
    idle();
    issue(enc_lit(core_pkg::op_intarith, 5'd6, 8'h02, core_pkg::fn_sub, 5'd17));
    issue(enc_reg(core_pkg::op_intarith, 5'd16, 5'd17, core_pkg::fn_sub, 5'd18));
    // r31 as destination and then as source at distances 1 and 3
    issue(enc_lit(core_pkg::op_intarith, 5'd1, 8'h05, core_pkg::fn_add, 5'd31));
    issue(enc_reg(core_pkg::op_intarith, 5'd31, 5'd31, core_pkg::fn_add, 5'd12));
    idle();
    issue(enc_reg(core_pkg::op_intlogic, 5'd31, 5'd2, core_pkg::fn_or, 5'd13));
    // illegal words leave r14 alone
    issue(enc_lit(6'h3f, 5'd1, 8'h01, core_pkg::fn_add, 5'd14));
    issue(enc_reg(core_pkg::op_intarith, 5'd14, 5'd2, 7'h7f, 5'd14));
    issue(enc_reg(core_pkg::op_intshift, 5'd14, 5'd2, 7'h00, 5'd14));
    issue(enc_reg(core_pkg::op_intarith, 5'd14, 5'd31, core_pkg::fn_add, 5'd15));
    issue({core_pkg::op_halt, 26'd0});
    while (exp_cyc.size() != 0) idle();
    repeat (3) idle();                    // halted must hold
    if (halted) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_failed("halted low at end of run");
    end
  end

endmodule

//--- src/pipe_core.sv
// pipe_core: top level, decode / execute / writeback stages and their wiring
module pipe_core (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             inst_valid,
  input  logic [core_pkg::inst_w-1:0]      inst,
  output logic                             wb_valid,
  output logic                             wb_illegal,
  output logic [core_pkg::reg_idx_w-1:0]   wb_idx,
  output logic [core_pkg::xlen-1:0]        wb_data,
  output logic                             halted
);

  // decode -> execute
  logic                              sx_valid, sx_use_lit, sx_halt, sx_illegal;
  core_pkg::alu_func_e               sx_func;
  logic [core_pkg::xlen-1:0]         sx_rega, sx_opb;
  logic [core_pkg::reg_idx_w-1:0]    sx_rega_idx, sx_regb_idx, sx_dest;

  // execute -> writeback
  logic                              xw_valid, xw_halt, xw_illegal;
  logic [core_pkg::reg_idx_w-1:0]    xw_dest;
  logic [core_pkg::xlen-1:0]         xw_data;

  // writeback -> register file
  logic                              rf_wr_en;
  logic [core_pkg::reg_idx_w-1:0]    rf_wr_idx;
  logic [core_pkg::xlen-1:0]         rf_wr_data;

  id_stage u_id_stage (
    .clock       (clock),       .rst         (rst),
    .inst_valid  (inst_valid),  .inst        (inst),
    .rf_wr_en    (rf_wr_en),    .rf_wr_idx   (rf_wr_idx),  .rf_wr_data (rf_wr_data),
    .sx_valid    (sx_valid),    .sx_func     (sx_func),
    .sx_rega     (sx_rega),     .sx_opb      (sx_opb),
    .sx_rega_idx (sx_rega_idx), .sx_regb_idx (sx_regb_idx),
    .sx_use_lit  (sx_use_lit),  .sx_dest     (sx_dest),
    .sx_halt     (sx_halt),     .sx_illegal  (sx_illegal)
  );

  ex_stage u_ex_stage (
    .clock       (clock),       .rst         (rst),
    .sx_valid    (sx_valid),    .sx_func     (sx_func),
    .sx_rega     (sx_rega),     .sx_opb      (sx_opb),
    .sx_rega_idx (sx_rega_idx), .sx_regb_idx (sx_regb_idx),
    .sx_use_lit  (sx_use_lit),  .sx_dest     (sx_dest),
    .sx_halt     (sx_halt),     .sx_illegal  (sx_illegal),
    .xw_valid    (xw_valid),    .xw_dest     (xw_dest),    .xw_data    (xw_data),
    .xw_halt     (xw_halt),     .xw_illegal  (xw_illegal)
  );

  wb_stage u_wb_stage (
    .clock      (clock),      .rst        (rst),
    .xw_valid   (xw_valid),   .xw_dest    (xw_dest),    .xw_data    (xw_data),
    .xw_halt    (xw_halt),    .xw_illegal (xw_illegal),
    .rf_wr_en   (rf_wr_en),   .rf_wr_idx  (rf_wr_idx),  .rf_wr_data (rf_wr_data),
    .wb_valid   (wb_valid),   .wb_illegal (wb_illegal),
    .wb_idx     (wb_idx),     .wb_data    (wb_data),
    .halted     (halted)
  );

endmodule

//--- src/wb_stage.sv
// wb_stage: register file write port, retire report register, sticky halted flag
module wb_stage (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             xw_valid,
  input  logic [core_pkg::reg_idx_w-1:0]   xw_dest,
  input  logic [core_pkg::xlen-1:0]        xw_data,
  input  logic                             xw_halt,
  input  logic                             xw_illegal,
  output logic                             rf_wr_en,
  output logic [core_pkg::reg_idx_w-1:0]   rf_wr_idx,
  output logic [core_pkg::xlen-1:0]        rf_wr_data,
  output logic                             wb_valid,
  output logic                             wb_illegal,
  output logic [core_pkg::reg_idx_w-1:0]   wb_idx,
  output logic [core_pkg::xlen-1:0]        wb_data,
  output logic                             halted
);

  // rf write lands on the same edge as the retire report
  assign rf_wr_en   = xw_valid & ~xw_illegal & ~xw_halt & (xw_dest != core_pkg::zero_reg);
  assign rf_wr_idx  = xw_dest;
  assign rf_wr_data = xw_data;

  always_ff @(posedge clock) begin
    if (rst) begin
      wb_valid   <= 1'b0;
      wb_illegal <= 1'b0;
      halted     <= 1'b0;
    end else begin
      wb_valid   <= xw_valid & ~xw_halt;          // halt never retires as a pulse
      wb_illegal <= xw_valid & xw_illegal;
      halted     <= halted | (xw_valid & xw_halt); // sticky until reset
    end
    wb_idx  <= xw_dest;
    wb_data <= xw_data;
  end

endmodule

//--- src/execute/ex_stage.sv
// ex_stage: one-step bypass, alu, execute-to-writeback register
module ex_stage (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             sx_valid,
  input  core_pkg::alu_func_e              sx_func,
  input  logic [core_pkg::xlen-1:0]        sx_rega,
  input  logic [core_pkg::xlen-1:0]        sx_opb,
  input  logic [core_pkg::reg_idx_w-1:0]   sx_rega_idx,
  input  logic [core_pkg::reg_idx_w-1:0]   sx_regb_idx,
  input  logic                             sx_use_lit,
  input  logic [core_pkg::reg_idx_w-1:0]   sx_dest,
  input  logic                             sx_halt,
  input  logic                             sx_illegal,
  output logic                             xw_valid,
  output logic [core_pkg::reg_idx_w-1:0]   xw_dest,
  output logic [core_pkg::xlen-1:0]        xw_data,
  output logic                             xw_halt,
  output logic                             xw_illegal
);

  logic                       prev_writes;   // instruction one step ahead will write rf
  logic                       fwd_a, fwd_b;
  logic [core_pkg::xlen-1:0]  opa, opb, alu_res;

  //////////////////////////////////////////////////
  // bypass from the xw register
  //////////////////////////////////////////////////
  assign prev_writes = xw_valid & ~xw_illegal & ~xw_halt & (xw_dest != core_pkg::zero_reg);
  assign fwd_a = prev_writes & (sx_rega_idx == xw_dest);
  assign fwd_b = prev_writes & ~sx_use_lit & (sx_regb_idx == xw_dest);  // literal never bypassed

  assign opa = fwd_a ? xw_data : sx_rega;
  assign opb = fwd_b ? xw_data : sx_opb;

  // alu
  always_comb begin
    case (sx_func)
      core_pkg::alu_add:   alu_res = opa + opb;
      core_pkg::alu_sub:   alu_res = opa - opb;
      core_pkg::alu_cmpeq: alu_res = {{(core_pkg::xlen-1){1'b0}}, (opa == opb)};
      core_pkg::alu_and:   alu_res = opa & opb;
      core_pkg::alu_or:    alu_res = opa | opb;
      core_pkg::alu_xor:   alu_res = opa ^ opb;
      core_pkg::alu_sll:   alu_res = opa << opb[5:0];   // shift amount, low 6 bits
      core_pkg::alu_srl:   alu_res = opa >> opb[5:0];
      default:             alu_res = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      xw_valid   <= 1'b0;
      xw_halt    <= 1'b0;
      xw_illegal <= 1'b0;
    end else begin
      xw_valid   <= sx_valid;
      xw_halt    <= sx_halt;
      xw_illegal <= sx_illegal;
    end
    xw_dest <= sx_dest;
    xw_data <= (sx_illegal | sx_halt) ? '0 : alu_res;  // illegal retires with zero data
  end

endmodule

//--- src/decode/id_stage.sv
// id_stage: decode stage, decoder plus register file, operand b select, decode-to-execute register
module id_stage (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             inst_valid,
  input  logic [core_pkg::inst_w-1:0]      inst,
  input  logic                             rf_wr_en,    // from writeback
  input  logic [core_pkg::reg_idx_w-1:0]   rf_wr_idx,
  input  logic [core_pkg::xlen-1:0]        rf_wr_data,
  output logic                             sx_valid,
  output core_pkg::alu_func_e              sx_func,
  output logic [core_pkg::xlen-1:0]        sx_rega,
  output logic [core_pkg::xlen-1:0]        sx_opb,      // literal already folded in
  output logic [core_pkg::reg_idx_w-1:0]   sx_rega_idx,
  output logic [core_pkg::reg_idx_w-1:0]   sx_regb_idx,
  output logic                             sx_use_lit,
  output logic [core_pkg::reg_idx_w-1:0]   sx_dest,
  output logic                             sx_halt,
  output logic                             sx_illegal
);

  core_pkg::alu_func_e               dec_func;
  logic                              dec_use_lit, dec_halt, dec_illegal, dec_valid;
  logic [core_pkg::reg_idx_w-1:0]    dec_dest;
  logic [core_pkg::reg_idx_w-1:0]    ra_idx, rb_idx;
  logic [core_pkg::xlen-1:0]         ra_val, rb_val, opb;
  logic [core_pkg::lit_w-1:0]        lit;

  assign ra_idx = inst[core_pkg::ra_hi:core_pkg::ra_lo];
  assign rb_idx = inst[core_pkg::rb_hi:core_pkg::rb_lo];
  assign lit    = inst[core_pkg::lit_hi:core_pkg::lit_lo];

  decoder u_decoder (
    .inst_valid (inst_valid),  .inst    (inst),
    .func       (dec_func),    .use_lit (dec_use_lit),
    .dest       (dec_dest),    .halt    (dec_halt),
    .illegal    (dec_illegal), .valid   (dec_valid)
  );

  regfile u_regfile (
    .clock   (clock),
    .rda_idx (ra_idx),   .rdb_idx (rb_idx),
    .wr_en   (rf_wr_en), .wr_idx  (rf_wr_idx), .wr_data (rf_wr_data),
    .rda_out (ra_val),   .rdb_out (rb_val)
  );

  // operand b is the zero-extended literal or rb
  assign opb = dec_use_lit ? {{(core_pkg::xlen-core_pkg::lit_w){1'b0}}, lit} : rb_val;

  //////////////////////////////////////////////////
  // decode -> execute register
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (rst) begin
      sx_valid   <= 1'b0;
      sx_halt    <= 1'b0;
      sx_illegal <= 1'b0;
    end else begin
      sx_valid   <= dec_valid;
      sx_halt    <= dec_halt;
      sx_illegal <= dec_illegal;
    end
    sx_func     <= dec_func;     // payload fields
    sx_rega     <= ra_val;
    sx_opb      <= opb;
    sx_rega_idx <= ra_idx;
    sx_regb_idx <= rb_idx;
    sx_use_lit  <= dec_use_lit;
    sx_dest     <= dec_dest;
  end

endmodule

//--- src/decode/decoder.sv
// decoder: combinational operate-format decode to alu function, operand select, dest, halt, illegal
module decoder (
  input  logic                                 inst_valid,
  input  logic [core_pkg::inst_w-1:0]          inst,
  output core_pkg::alu_func_e                  func,
  output logic                                 use_lit,   // literal instead of rb
  output logic [core_pkg::reg_idx_w-1:0]       dest,
  output logic                                 halt,
  output logic                                 illegal,
  output logic                                 valid
);

  core_pkg::opcode_e                 opcode;
  logic [core_pkg::func_w-1:0]       fcode;
  logic                              bad;       // unknown opcode or func code
  logic                              is_halt;

  assign opcode = core_pkg::opcode_e'(inst[core_pkg::op_hi:core_pkg::op_lo]);
  assign fcode  = inst[core_pkg::func_hi:core_pkg::func_lo];

  always_comb begin
    func    = core_pkg::alu_add;  // halt and illegal words keep alu_add
    bad     = 1'b0;
    is_halt = 1'b0;
    case (opcode)
      core_pkg::op_halt: is_halt = 1'b1;
      core_pkg::op_intarith: begin
        case (fcode)
          core_pkg::fn_add:   func = core_pkg::alu_add;
          core_pkg::fn_sub:   func = core_pkg::alu_sub;
          core_pkg::fn_cmpeq: func = core_pkg::alu_cmpeq;
          default:            bad  = 1'b1;
        endcase
      end
      core_pkg::op_intlogic: begin
        case (fcode)
          core_pkg::fn_and: func = core_pkg::alu_and;
          core_pkg::fn_or:  func = core_pkg::alu_or;
          core_pkg::fn_xor: func = core_pkg::alu_xor;
          default:          bad  = 1'b1;
        endcase
      end
      core_pkg::op_intshift: begin
        case (fcode)
          core_pkg::fn_sll: func = core_pkg::alu_sll;
          core_pkg::fn_srl: func = core_pkg::alu_srl;
          default:          bad  = 1'b1;
        endcase
      end
      default: bad = 1'b1;                      // opcode outside the supported set
    endcase
  end

  assign use_lit = inst[core_pkg::lit_flag_bit];
  assign dest    = inst[core_pkg::rc_hi:core_pkg::rc_lo];
  assign valid   = inst_valid;
  assign halt    = inst_valid & is_halt;   // flags only mean something on a valid word
  assign illegal = inst_valid & bad;

endmodule

//--- src/decode/regfile.sv
// regfile: 32 x 64 register file, two read ports, one write port, write-through, r31 reads zero
module regfile (
  input  logic                             clock,
  input  logic [core_pkg::reg_idx_w-1:0]   rda_idx,
  input  logic [core_pkg::reg_idx_w-1:0]   rdb_idx,
  input  logic                             wr_en,
  input  logic [core_pkg::reg_idx_w-1:0]   wr_idx,
  input  logic [core_pkg::xlen-1:0]        wr_data,
  output logic [core_pkg::xlen-1:0]        rda_out,
  output logic [core_pkg::xlen-1:0]        rdb_out
);

  logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_idx_w];  // architectural registers

  // port a prefers zero reg over write-through over the array
  always_comb begin
    if (rda_idx == core_pkg::zero_reg) rda_out = '0;
    else if (wr_en && (wr_idx == rda_idx)) rda_out = wr_data;
    else rda_out = regs[rda_idx];
  end

  // read port b with the same priority
  always_comb begin
    if (rdb_idx == core_pkg::zero_reg) rdb_out = '0;
    else if (wr_en && (wr_idx == rdb_idx)) rdb_out = wr_data;
    else rdb_out = regs[rdb_idx];
  end

  always_ff @(posedge clock) begin
    if (wr_en && (wr_idx != core_pkg::zero_reg)) begin
      regs[wr_idx] <= wr_data;               // r31 never takes a value
    end
  end

endmodule

//--- common/core_pkg.sv
// core_pkg: widths, instruction field positions, opcode and alu function enums, func codes
package core_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int xlen      = 64;   // integer datapath width
  localparam int inst_w    = 32;   // instruction word
  localparam int reg_idx_w = 5;    // 32 architectural regs
  localparam int op_w      = 6;
  localparam int func_w    = 7;
  localparam int lit_w     = 8;    // zero-extended literal

  localparam logic [reg_idx_w-1:0] zero_reg = 5'd31; // reads zero, drops writes

  //////////////////////////////////////////////////
  // instruction field positions, operate format
  //////////////////////////////////////////////////
  localparam int op_hi        = 31;
  localparam int op_lo        = 26;
  localparam int ra_hi        = 25;
  localparam int ra_lo        = 21;
  localparam int rb_hi        = 20;   // rb and literal overlap
  localparam int rb_lo        = 16;
  localparam int lit_hi       = 20;
  localparam int lit_lo       = 13;
  localparam int lit_flag_bit = 12;   // 1 = literal replaces rb
  localparam int func_hi      = 11;
  localparam int func_lo      = 5;
  localparam int rc_hi        = 4;    // destination
  localparam int rc_lo        = 0;

  //////////////////////////////////////////////////
  // opcodes and alu functions
  //////////////////////////////////////////////////
  typedef enum logic [op_w-1:0] {
    op_halt     = 6'h00,
    op_intarith = 6'h10,
    op_intlogic = 6'h11,
    op_intshift = 6'h12
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_cmpeq,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl
  } alu_func_e;

  // func codes under op_intarith
  localparam logic [func_w-1:0] fn_add   = 7'h20;
  localparam logic [func_w-1:0] fn_sub   = 7'h29;
  localparam logic [func_w-1:0] fn_cmpeq = 7'h2d;

  // func codes under op_intlogic
  localparam logic [func_w-1:0] fn_and   = 7'h00;
  localparam logic [func_w-1:0] fn_or    = 7'h20;  // same code as add, other opcode
  localparam logic [func_w-1:0] fn_xor   = 7'h40;

  // func codes under op_intshift
  localparam logic [func_w-1:0] fn_sll   = 7'h39;
  localparam logic [func_w-1:0] fn_srl   = 7'h34;

endpackage
